//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_cp_subsystem
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
logic/cp_pkg.sv
logic/cp_predecode.sv
logic/coproc_unit.sv
logic/regfile_arbiter.sv
logic/phys_regfile.sv
logic/cp_subsystem_top.sv
tests/tb_cp_subsystem.sv

//--- logic/coproc_unit.sv
`timescale 1ns/1ps

module coproc_unit
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  cp_pkg::copro_req_t      i_copro,
        input  logic                    i_rf_gnt,
        input  cp_pkg::word_t           i_rf_rdata,
        output logic                    o_copro_done,
        output cp_pkg::rf_req_t         o_rf
);

cp_pkg::cpu_state_t     state_ff;
cp_pkg::word_t          cmd_word;
cp_pkg::phys_reg_t      cmd_preg;
cp_pkg::word_t          cp_regs [16];

cp_pkg::arch_reg_t      crn;
logic                   is_xfer;
logic                   is_mrc;
logic                   xfer_done;

assign crn     = cmd_word[cp_pkg::INSN_RN_LO +: 4];
assign is_mrc  = cmd_word[cp_pkg::INSN_L_BIT];

// MCR or MRC. Everything else retires without effect.
assign is_xfer = (cmd_word[cp_pkg::INSN_CLASS_LO +: 4] == cp_pkg::OPC_CP_REG) &&
                 cmd_word[cp_pkg::INSN_OP_BIT];

// Request drops if predecode withdraws dav.
always_comb
begin
        o_rf.req   = (state_ff == cp_pkg::CPU_ACCESS) && is_xfer && i_copro.dav;
        o_rf.we    = o_rf.req && is_mrc;
        o_rf.addr  = cmd_preg;
        o_rf.wdata = cp_regs[crn];
end

assign xfer_done    = o_rf.req && i_rf_gnt;
assign o_copro_done = (state_ff == cp_pkg::CPU_DONE);

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff <= cp_pkg::CPU_IDLE;
        end
        else
        begin
                case (state_ff)
                cp_pkg::CPU_IDLE:
                begin
                        if (i_copro.dav)
                                state_ff <= cp_pkg::CPU_ACCESS;
                end
                cp_pkg::CPU_ACCESS:
                begin
                        if (!i_copro.dav)
                                state_ff <= cp_pkg::CPU_IDLE;   // Cleared upstream.
                        else if (!is_xfer || xfer_done)
                                state_ff <= cp_pkg::CPU_DONE;
                end
                cp_pkg::CPU_DONE:
                begin
                        state_ff <= cp_pkg::CPU_IDLE;
                end
                default:
                begin
                        state_ff <= cp_pkg::CPU_IDLE;
                end
                endcase
        end
end

// Command captured on acceptance.
always_ff @(posedge i_clk)
begin
        if (state_ff == cp_pkg::CPU_IDLE && i_copro.dav)
        begin
                cmd_word <= i_copro.word;
                cmd_preg <= i_copro.preg;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < 16; i++)
                        cp_regs[i] <= '0;
        end
        else if (xfer_done && !is_mrc)
        begin
                cp_regs[crn] <= i_rf_rdata;     // MCR lands here.
        end
end

endmodule

//--- logic/cp_pkg.sv
package cp_pkg;

        localparam int PHY_REGS_DEFAULT = 46;

        typedef logic [31:0] word_t;
        typedef logic [3:0]  arch_reg_t;
        typedef logic [5:0]  phys_reg_t;
        typedef logic [31:0] cpsr_t;

        // ARM mode encodings.
        typedef enum logic [4:0] {
                USR = 5'h10,
                FIQ = 5'h11,
                IRQ = 5'h12,
                SVC = 5'h13,
                ABT = 5'h17,
                UND = 5'h1b,
                SYS = 5'h1f
        } mode_t;

        localparam int CPSR_T       = 5;
        localparam int CPSR_MODE_HI = 4;
        localparam int CPSR_MODE_LO = 0;

        localparam int INSN_CLASS_LO = 24;
        localparam int INSN_RN_LO    = 16;   // CRn, or base register of LDC/STC.
        localparam int INSN_RD_LO    = 12;   // Core register of MCR/MRC.
        localparam int INSN_L_BIT    = 20;
        localparam int INSN_OP_BIT   = 4;

        localparam logic [3:0] OPC_CP_REG = 4'b1110;   // MCR, MRC, CDP.
        localparam logic [2:0] OPC_CP_MEM = 3'b110;    // LDC, STC.

        typedef enum logic {CP_IDLE, CP_BUSY} cp_state_t;
        typedef enum logic [1:0] {CPU_IDLE, CPU_ACCESS, CPU_DONE} cpu_state_t;

        typedef struct packed {
                logic      dav;
                word_t     word;
                phys_reg_t preg;
        } copro_req_t;

        typedef struct packed {
                logic      req;
                logic      we;
                phys_reg_t addr;
                word_t     wdata;
        } rf_req_t;

        // Architectural register to physical slot for a given mode.
        function automatic phys_reg_t bank_map(input arch_reg_t r, input mode_t m);
                phys_reg_t p;
                p = phys_reg_t'(r);
                case (m)
                FIQ: if (r >= 4'd8 && r <= 4'd14) p = phys_reg_t'(r) + 6'd8;
                IRQ: if (r == 4'd13 || r == 4'd14) p = phys_reg_t'(r) + 6'd10;
                SVC: if (r == 4'd13 || r == 4'd14) p = phys_reg_t'(r) + 6'd12;
                ABT: if (r == 4'd13 || r == 4'd14) p = phys_reg_t'(r) + 6'd14;
                UND: if (r == 4'd13 || r == 4'd14) p = phys_reg_t'(r) + 6'd16;
                default: p = phys_reg_t'(r);
                endcase
                return p;
        endfunction

endpackage

//--- logic/cp_predecode.sv
`timescale 1ns/1ps

module cp_predecode #(
        parameter int PHY_REGS = 46
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  cp_pkg::word_t           i_instruction,
        input  logic                    i_valid,
        input  cp_pkg::cpsr_t           i_cpsr,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        input  logic                    i_clear,
        input  logic                    i_stall,
        input  logic                    i_pipeline_dav,
        input  logic                    i_copro_done,
        output cp_pkg::word_t           o_instruction,
        output logic                    o_valid,
        output logic                    o_irq,
        output logic                    o_fiq,
        output logic                    o_stall,
        output cp_pkg::copro_req_t      o_copro
);

cp_pkg::cp_state_t      state_ff;
cp_pkg::cp_state_t      state_nxt;
cp_pkg::copro_req_t     copro_ff;
cp_pkg::copro_req_t     copro_nxt;

logic                   is_cp_reg;
logic                   is_cp_mem;
logic                   is_cp;
cp_pkg::arch_reg_t      core_reg;
cp_pkg::phys_reg_t      xlat_reg;

assign is_cp_reg = (i_instruction[cp_pkg::INSN_CLASS_LO +: 4] == cp_pkg::OPC_CP_REG);
assign is_cp_mem = (i_instruction[cp_pkg::INSN_CLASS_LO + 1 +: 3] == cp_pkg::OPC_CP_MEM);

// ARM state only.
assign is_cp = i_valid && !i_cpsr[cp_pkg::CPSR_T] && (is_cp_reg || is_cp_mem);

assign core_reg = is_cp_mem ? i_instruction[cp_pkg::INSN_RN_LO +: 4]
                            : i_instruction[cp_pkg::INSN_RD_LO +: 4];

assign xlat_reg = cp_pkg::bank_map(core_reg,
                cp_pkg::mode_t'(i_cpsr[cp_pkg::CPSR_MODE_HI:cp_pkg::CPSR_MODE_LO]));

assign o_copro = copro_ff;

always_comb
begin
        state_nxt     = state_ff;
        copro_nxt     = copro_ff;
        o_instruction = i_instruction;
        o_valid       = i_valid;
        o_irq         = i_irq;
        o_fiq         = i_fiq;
        o_stall       = 1'b0;

        case (state_ff)
        cp_pkg::CP_IDLE:
        begin
                copro_nxt.dav = 1'b0;
                if (is_cp)
                begin
                        // Instruction and its interrupts leave the pipe.
                        o_instruction = '0;
                        o_valid       = 1'b0;
                        o_irq         = 1'b0;
                        o_fiq         = 1'b0;
                        o_stall       = 1'b1;

                        if (!i_pipeline_dav)   // Older work drained.
                        begin
                                copro_nxt.dav  = 1'b1;
                                copro_nxt.word = i_instruction;
                                copro_nxt.preg = (xlat_reg < PHY_REGS) ? xlat_reg : '0;
                                state_nxt      = cp_pkg::CP_BUSY;
                        end
                end
        end
        cp_pkg::CP_BUSY:
        begin
                o_instruction = '0;
                o_valid       = 1'b0;
                o_irq         = 1'b0;
                o_fiq         = 1'b0;
                o_stall       = !i_copro_done;

                if (i_copro_done)
                begin
                        copro_nxt.dav = 1'b0;
                        state_nxt     = cp_pkg::CP_IDLE;
                end
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                state_ff <= cp_pkg::CP_IDLE;
                copro_ff <= '0;
        end
        else if (!i_stall)
        begin
                state_ff <= state_nxt;
                copro_ff <= copro_nxt;
        end
end

endmodule

//--- logic/cp_subsystem_top.sv
`timescale 1ns/1ps

module cp_subsystem_top #(
        parameter int PHY_REGS = cp_pkg::PHY_REGS_DEFAULT
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  cp_pkg::word_t           i_instruction,
        input  logic                    i_valid,
        input  cp_pkg::cpsr_t           i_cpsr,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        input  logic                    i_clear,
        input  logic                    i_stall,
        input  logic                    i_pipeline_dav,
        input  cp_pkg::rf_req_t         i_ext,
        output cp_pkg::word_t           o_instruction,
        output logic                    o_valid,
        output logic                    o_irq,
        output logic                    o_fiq,
        output logic                    o_stall,
        output cp_pkg::copro_req_t      o_copro,
        output logic                    o_ext_gnt,
        output cp_pkg::word_t           o_ext_rdata
);

cp_pkg::copro_req_t     copro;
logic                   copro_done;
cp_pkg::rf_req_t        cp_rf;
logic                   cp_gnt;
cp_pkg::rf_req_t        rf_port;
cp_pkg::word_t          rf_rdata;

assign o_copro     = copro;
assign o_ext_rdata = rf_rdata;   // Shared read bus.

cp_predecode #(
        .PHY_REGS       (PHY_REGS)
) cp_predecode_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instruction  (i_instruction),
        .i_valid        (i_valid),
        .i_cpsr         (i_cpsr),
        .i_irq          (i_irq),
        .i_fiq          (i_fiq),
        .i_clear        (i_clear),
        .i_stall        (i_stall),
        .i_pipeline_dav (i_pipeline_dav),
        .i_copro_done   (copro_done),
        .o_instruction  (o_instruction),
        .o_valid        (o_valid),
        .o_irq          (o_irq),
        .o_fiq          (o_fiq),
        .o_stall        (o_stall),
        .o_copro        (copro)
);

coproc_unit coproc_unit_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_copro        (copro),
        .i_rf_gnt       (cp_gnt),
        .i_rf_rdata     (rf_rdata),
        .o_copro_done   (copro_done),
        .o_rf           (cp_rf)
);

regfile_arbiter regfile_arbiter_i (
        .i_ext          (i_ext),
        .i_cp           (cp_rf),
        .o_ext_gnt      (o_ext_gnt),
        .o_cp_gnt       (cp_gnt),
        .o_port         (rf_port)
);

phys_regfile #(
        .PHY_REGS       (PHY_REGS)
) phys_regfile_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_port         (rf_port),
        .o_rdata        (rf_rdata)
);

endmodule

//--- logic/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile #(
        parameter int PHY_REGS = 46
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  cp_pkg::rf_req_t         i_port,
        output cp_pkg::word_t           o_rdata
);

cp_pkg::word_t  regs [PHY_REGS];
logic           addr_ok;

assign addr_ok = (i_port.addr < PHY_REGS);

// Read is combinational.
assign o_rdata = addr_ok ? regs[i_port.addr] : '0;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                for (int i = 0; i < PHY_REGS; i++)
                        regs[i] <= '0;
        end
        else if (i_port.req && i_port.we && addr_ok)
        begin
                regs[i_port.addr] <= i_port.wdata;
        end
end

endmodule

//--- logic/regfile_arbiter.sv
`timescale 1ns/1ps

module regfile_arbiter
(
        input  cp_pkg::rf_req_t         i_ext,
        input  cp_pkg::rf_req_t         i_cp,
        output logic                    o_ext_gnt,
        output logic                    o_cp_gnt,
        output cp_pkg::rf_req_t         o_port
);

// External port always wins.
assign o_ext_gnt = i_ext.req;
assign o_cp_gnt  = i_cp.req && !i_ext.req;

always_comb
begin
        if (o_ext_gnt)
        begin
                o_port = i_ext;
        end
        else if (o_cp_gnt)
        begin
                o_port = i_cp;
        end
        else
        begin
                // Idle port, no write.
                o_port = '0;
        end
end

endmodule

//--- tests/tb_cp_subsystem.sv
`timescale 1ns/1ps

module tb_cp_subsystem;

localparam int PHY_REGS   = cp_pkg::PHY_REGS_DEFAULT;
localparam int N_PASS     = 40;
localparam int N_XFER     = 8;
localparam int N_BUSY     = 4;
localparam int NUM_TXN    = N_PASS + 1 + 3 * PHY_REGS + 3 * (N_XFER + N_BUSY) + 9;
localparam int MAX_CYCLES = NUM_TXN * 40 + 200;

logic                   i_clk;
logic                   i_reset;
cp_pkg::word_t          i_instruction;
logic                   i_valid;
cp_pkg::cpsr_t          i_cpsr;
logic                   i_irq;
logic                   i_fiq;
logic                   i_clear;
logic                   i_stall;
logic                   i_pipeline_dav;
cp_pkg::rf_req_t        i_ext;
cp_pkg::word_t          o_instruction;
logic                   o_valid;
logic                   o_irq;
logic                   o_fiq;
logic                   o_stall;
cp_pkg::copro_req_t     o_copro;
logic                   o_ext_gnt;
cp_pkg::word_t          o_ext_rdata;

cp_pkg::word_t          phys_shadow [PHY_REGS];
cp_pkg::word_t          cp_shadow [16];
int                     value_errors = 0;
int                     timeout_errors = 0;
int                     cycles = 0;

cp_subsystem_top #(.PHY_REGS(PHY_REGS)) cp_subsystem_top_i (.*);

initial i_clk = 1'b0;
always #2 i_clk = ~i_clk;

// Physical slot of an architectural register, per the banking table.
function automatic cp_pkg::phys_reg_t expected_preg(input cp_pkg::arch_reg_t r,
                                                      input cp_pkg::mode_t m);
        int idx;
        idx = int'(r);
        if (m == cp_pkg::FIQ && r >= 4'd8 && r <= 4'd14)
                idx = 16 + (idx - 8);
        else if (r == 4'd13 || r == 4'd14)
        begin
                case (m)
                cp_pkg::IRQ: idx = 23 + (idx - 13);
                cp_pkg::SVC: idx = 25 + (idx - 13);
                cp_pkg::ABT: idx = 27 + (idx - 13);
                cp_pkg::UND: idx = 29 + (idx - 13);
                default: idx = int'(r);
                endcase
        end
        return cp_pkg::phys_reg_t'(idx);
endfunction

// Core register an MCR, MRC, LDC or STC names, banked for the mode.
function automatic cp_pkg::phys_reg_t named_preg(input cp_pkg::word_t insn,
                                                 input cp_pkg::mode_t m);
        if (insn[27:25] == 3'b110)
                return expected_preg(insn[19:16], m);
        return expected_preg(insn[15:12], m);
endfunction

function automatic cp_pkg::cpsr_t make_cpsr(input cp_pkg::mode_t m, input logic thumb);
        cp_pkg::cpsr_t c;
        c      = '0;
        c[4:0] = m;
        c[5]   = thumb;
        return c;
endfunction

function automatic cp_pkg::mode_t random_mode();
        case ($urandom_range(0, 6))
        0: return cp_pkg::USR;
        1: return cp_pkg::FIQ;
        2: return cp_pkg::IRQ;
        3: return cp_pkg::SVC;
        4: return cp_pkg::ABT;
        5: return cp_pkg::UND;
        default: return cp_pkg::SYS;
        endcase
endfunction

// MCR when l is 0, MRC when l is 1.
function automatic cp_pkg::word_t make_xfer(input logic l, input cp_pkg::arch_reg_t crn,
                                            input cp_pkg::arch_reg_t rd);
        return {4'hE, 4'b1110, 3'd0, l, crn, rd, 4'd7, 3'd0, 1'b1, 4'd0};
endfunction

function automatic cp_pkg::word_t make_cdp(input cp_pkg::arch_reg_t crn);
        return {4'hE, 4'b1110, 4'd3, crn, 4'd2, 4'd7, 3'd1, 1'b0, 4'd5};
endfunction

function automatic cp_pkg::word_t make_ldst(input logic l, input cp_pkg::arch_reg_t rn);
        return {4'hE, 3'b110, 4'b1100, l, rn, 4'd1, 4'd7, 8'h04};
endfunction

task automatic check_word(input cp_pkg::word_t got, input cp_pkg::word_t exp, input string what);
        if (got !== exp)
        begin
                value_errors++;
                $display("FAILED %0t: %s is %h, expected %h", $realtime, what, got, exp);
        end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
                value_errors++;
                $display("FAILED %0t: %s is %b, expected %b", $realtime, what, got, exp);
        end
endtask

task automatic check_preg(input cp_pkg::phys_reg_t got, input cp_pkg::phys_reg_t exp,
                          input string what);
        if (got !== exp)
        begin
                value_errors++;
                $display("FAILED %0t: %s is %0d, expected %0d", $realtime, what, got, exp);
        end
endtask

task automatic next_cycle();
        @(posedge i_clk);
        #0.5;
endtask

task automatic apply_model(input cp_pkg::word_t insn, input cp_pkg::mode_t mode);
        cp_pkg::phys_reg_t preg;
        int crn;
        if (insn[27:24] == 4'b1110 && insn[4])
        begin
                preg = expected_preg(insn[15:12], mode);
                crn  = int'(insn[19:16]);
                if (insn[20])
                        phys_shadow[preg] = cp_shadow[crn];     // MRC.
                else
                        cp_shadow[crn] = phys_shadow[preg];     // MCR.
        end
endtask

task automatic drive_random_ext_write();
        cp_pkg::phys_reg_t addr;
        addr        = cp_pkg::phys_reg_t'($urandom_range(0, PHY_REGS - 1));
        i_ext.req   = 1'b1;
        i_ext.we    = 1'b1;
        i_ext.addr  = addr;
        i_ext.wdata = $urandom();
        phys_shadow[addr] = i_ext.wdata;
endtask

task automatic ext_access(input logic we, input cp_pkg::phys_reg_t addr, input cp_pkg::word_t data);
        i_ext = '{req: 1'b1, we: we, addr: addr, wdata: data};
        if (we)
                phys_shadow[addr] = data;
        @(negedge i_clk);
        check_bit(o_ext_gnt, 1'b1, "external grant");
        if (!we)
                check_word(o_ext_rdata, phys_shadow[addr], $sformatf("read of p%0d", addr));
        next_cycle();
        i_ext = '0;
endtask

task automatic check_all_regs();
        for (int i = 0; i < PHY_REGS; i++)
                ext_access(1'b0, cp_pkg::phys_reg_t'(i), '0);
endtask

task automatic check_suppressed();
        check_bit(o_valid, 1'b0, "valid of coprocessor instruction");
        check_bit(o_irq, 1'b0, "irq of coprocessor instruction");
        check_bit(o_fiq, 1'b0, "fiq of coprocessor instruction");
endtask

task automatic issue_cp(input cp_pkg::word_t insn, input cp_pkg::mode_t mode,
                        input int dav_cycles, input int ext_cycles);
        int waited;
        logic done;
        i_instruction  = insn;
        i_valid        = 1'b1;
        i_cpsr         = make_cpsr(mode, 1'b0);
        i_irq          = 1'($urandom_range(0, 1));
        i_fiq          = 1'($urandom_range(0, 1));
        i_pipeline_dav = 1'b1;
        for (int c = 0; c < dav_cycles; c++)
        begin
                @(negedge i_clk);
                check_suppressed();
                check_bit(o_stall, 1'b1, "stall while older work drains");
                check_bit(o_copro.dav, 1'b0, "request while older work drains");
                next_cycle();
        end
        i_pipeline_dav = 1'b0;
        waited = 0;
        done   = 1'b0;
        while (!done)
        begin
                if (waited < ext_cycles)
                        drive_random_ext_write();
                else
                        i_ext = '0;
                @(negedge i_clk);
                check_suppressed();
                if (waited == 1)        // First cycle after capture.
                begin
                        check_bit(o_copro.dav, 1'b1, "request dav");
                        check_word(o_copro.word, insn, "request word");
                        if (insn[27:24] != 4'b1110 || insn[4])
                                check_preg(o_copro.preg, named_preg(insn, mode),
                                           "request register");
                end
                if (waited < ext_cycles)
                        check_bit(o_stall, 1'b1, "stall under external traffic");
                if (!o_stall)
                        done = 1'b1;
                else if (waited >= 200)
                begin
                        timeout_errors++;
                        $display("Stall never dropped for instruction %h", insn);
                        done = 1'b1;
                end
                else
                begin
                        waited++;
                        next_cycle();
                end
        end
        if (!o_stall)
                apply_model(insn, mode);
        next_cycle();
        i_valid       = 1'b0;
        i_instruction = '0;
        i_ext         = '0;
endtask

task automatic clear_during_busy(input cp_pkg::word_t insn, input cp_pkg::mode_t mode);
        i_instruction  = insn;
        i_valid        = 1'b1;
        i_cpsr         = make_cpsr(mode, 1'b0);
        i_pipeline_dav = 1'b0;
        for (int c = 0; c < 4; c++)
        begin
                drive_random_ext_write();       // Holds off the grant.
                if (c == 3)
                begin
                        i_clear       = 1'b1;
                        i_valid       = 1'b0;
                        i_instruction = '0;
                end
                @(negedge i_clk);
                check_bit(o_stall, 1'b1, "stall before clear");
                next_cycle();
        end
        i_clear = 1'b0;
        i_ext   = '0;
        @(negedge i_clk);
        check_bit(o_stall, 1'b0, "stall after clear");
        next_cycle();
        next_cycle();
endtask

task automatic pass_through(input int count);
        cp_pkg::word_t insn;
        logic thumb;
        for (int n = 0; n < count; n++)
        begin
                thumb = 1'($urandom_range(0, 1));
                insn  = $urandom();
                if (thumb)
                        insn = make_xfer(1'($urandom_range(0, 1)), 4'($urandom()), 4'd3);
                else
                        insn[27:26] = 2'b00;    // Data processing space.
                i_instruction  = insn;
                i_valid        = 1'($urandom_range(0, 1));
                i_cpsr         = make_cpsr(random_mode(), thumb);
                i_irq          = 1'($urandom_range(0, 1));
                i_fiq          = 1'($urandom_range(0, 1));
                i_pipeline_dav = 1'($urandom_range(0, 1));
                @(negedge i_clk);
                check_word(o_instruction, insn, "passed instruction");
                check_bit(o_valid, i_valid, "passed valid");
                check_bit(o_irq, i_irq, "passed irq");
                check_bit(o_fiq, i_fiq, "passed fiq");
                check_bit(o_stall, 1'b0, "stall on ordinary instruction");
                next_cycle();
        end
        i_valid = 1'b0;
        i_irq   = 1'b0;
        i_fiq   = 1'b0;
endtask

initial
begin
        while (cycles < MAX_CYCLES)
        begin
                @(posedge i_clk);
                cycles++;
        end
        timeout_errors++;
        $display("Cycle limit of %0d reached before the tests finished", MAX_CYCLES);
        $display("Value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        $display("ERRORS FOUND");
        $finish;
end

initial
begin
        cp_pkg::arch_reg_t      src;
        cp_pkg::arch_reg_t      dst;
        cp_pkg::arch_reg_t      crn;
        cp_pkg::mode_t          m_src;
        cp_pkg::mode_t          m_dst;
        i_reset        = 1'b1;
        i_instruction  = '0;
        i_valid        = 1'b0;
        i_cpsr         = make_cpsr(cp_pkg::USR, 1'b0);
        i_irq          = 1'b0;
        i_fiq          = 1'b0;
        i_clear        = 1'b0;
        i_stall        = 1'b0;
        i_pipeline_dav = 1'b0;
        i_ext          = '0;
        void'($urandom(32'hd6153d73));
        for (int i = 0; i < PHY_REGS; i++)
                phys_shadow[i] = '0;
        for (int i = 0; i < 16; i++)
                cp_shadow[i] = '0;
        repeat (4) @(posedge i_clk);
        #0.5;
        i_reset = 1'b0;

        pass_through(N_PASS);
        issue_cp(make_cdp(4'd1), random_mode(), 5, 0);         // Stall held by a busy pipe.
        for (int i = 0; i < PHY_REGS; i++)
                ext_access(1'b1, cp_pkg::phys_reg_t'(i), $urandom());

        for (int n = 0; n < N_XFER + N_BUSY; n++)
        begin
                src   = cp_pkg::arch_reg_t'($urandom_range(0, 14));
                dst   = cp_pkg::arch_reg_t'($urandom_range(0, 14));
                crn   = cp_pkg::arch_reg_t'($urandom());
                m_src = random_mode();
                m_dst = random_mode();
                ext_access(1'b1, expected_preg(src, m_src), $urandom());
                // The last N_BUSY rounds compete with external writes.
                issue_cp(make_xfer(1'b0, crn, src), m_src, $urandom_range(0, 2),
                         (n < N_XFER) ? 0 : $urandom_range(3, 8));
                issue_cp(make_xfer(1'b1, crn, dst), m_dst, $urandom_range(0, 2),
                         (n < N_XFER) ? 0 : $urandom_range(3, 8));
                ext_access(1'b0, expected_preg(dst, m_dst), '0);
        end

        issue_cp(make_ldst(1'b1, 4'($urandom())), random_mode(), 1, 0);
        issue_cp(make_ldst(1'b0, 4'($urandom())), random_mode(), 0, 0);
        issue_cp(make_cdp(4'($urandom())), random_mode(), 0, 0);
        check_all_regs();

        src   = cp_pkg::arch_reg_t'($urandom_range(0, 14));
        dst   = cp_pkg::arch_reg_t'($urandom_range(0, 14));
        crn   = cp_pkg::arch_reg_t'($urandom());
        m_src = random_mode();
        m_dst = random_mode();
        issue_cp(make_xfer(1'b0, crn, src), m_src, 0, 0);
        ext_access(1'b1, expected_preg(src, m_src), $urandom());
        clear_during_busy(make_xfer(1'b0, crn, src), m_src);
        issue_cp(make_xfer(1'b1, crn, dst), m_dst, 0, 0);
        ext_access(1'b0, expected_preg(dst, m_dst), '0);
        check_all_regs();

        $display("Value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
                $display("NO ERRORS");
        else
                $display("ERRORS FOUND");
        $finish;
end

endmodule
